// File: build.f
hw/fat_pkg.sv
hw/boot_record_parser.sv
hw/dir_entry_matcher.sv
hw/fat_sequencer.sv
hw/file_byte_streamer.sv
hw/fat_reader_top.sv
tests/tb_clock_gen.sv
tests/tb_fat_reader.sv

// File: hw/boot_record_parser.sv
// boot record parser for MBR and FAT16 volume boot record sectors
// keeps the signature, jump byte, partition start and BPB bytes
// and derives the volume layout from them
`timescale 1ns/1ps
`default_nettype none

module boot_record_parser (
    input  wire                  clk,
    input  wire                  rst_n,
    input  fat_pkg::read_phase_t phase,
    input  wire                  beat_fire,
    input  fat_pkg::byte_beat_t  beat,
    output fat_pkg::volume_layout_t layout,
    output logic                 is_boot,
    output logic                 is_dbr,
    output fat_pkg::sector_no_t  part_start,
    output logic                 fs_ok,
    input  fat_pkg::sector_no_t  base_sector
);
    import fat_pkg::*;

    logic [7:0]  jump_byte;
    logic [7:0]  bpb [0:12];         // offsets 0x0B to 0x17
    logic [7:0]  part_bytes [0:3];   // first partition LBA, 0x1C6 to 0x1C9
    logic [7:0]  sig_bytes [0:1];
    logic        captured;           // a whole sector has been seen
    logic        capture;
    logic [15:0] bytes_per_sec;
    logic [15:0] reserved_secs;
    logic [15:0] root_entries;
    logic [15:0] fat_size;

    assign capture = beat_fire && (phase == phase_find_mbr || phase == phase_find_dbr);

    always_ff @(posedge clk) begin
        if (capture) begin
            if (beat.offset == 9'h000)
                jump_byte <= beat.data;
            if (beat.offset >= 9'h00B && beat.offset <= 9'h017)
                bpb[beat.offset[3:0] - 4'd11] <= beat.data;
            if (beat.offset >= 9'h1C6 && beat.offset <= 9'h1C9)
                part_bytes[beat.offset[1:0] - 2'd2] <= beat.data;
            if (beat.offset >= 9'h1FE)
                sig_bytes[beat.offset[0]] <= beat.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            captured <= 1'b0;
        else if (capture && beat.last)
            captured <= 1'b1;
    end

    assign bytes_per_sec = {bpb[1], bpb[0]};
    assign reserved_secs = {bpb[4], bpb[3]};
    assign root_entries  = {bpb[7], bpb[6]};
    assign fat_size      = {bpb[12], bpb[11]};

    assign is_boot    = captured && sig_bytes[0] == 8'h55 && sig_bytes[1] == 8'hAA;
    assign is_dbr     = captured && (jump_byte == 8'hEB || jump_byte == 8'hE9);
    assign part_start = {part_bytes[3], part_bytes[2], part_bytes[1], part_bytes[0]};
    assign fs_ok      = bytes_per_sec == 16'(sector_bytes) && fat_size != 16'd0;

    assign layout.sec_per_clus = bpb[2];
    assign layout.fat_start    = base_sector + {16'd0, reserved_secs};
    assign layout.root_start   = layout.fat_start + {16'd0, fat_size} * {24'd0, bpb[5]};
    assign layout.root_count   = 16'(({16'd0, root_entries} * dir_entry_bytes) / sector_bytes);
    assign layout.data_start   = layout.root_start + {16'd0, layout.root_count}
                                 - {23'd0, bpb[2], 1'b0};  // cluster 2 is the first data cluster

endmodule

`default_nettype wire

// File: hw/dir_entry_matcher.sv
// root directory entry matcher on the raw 8.3 short name
// latches first cluster and size of the first matching file entry
`timescale 1ns/1ps
`default_nettype none

module dir_entry_matcher #(
    parameter logic [8*11-1:0] target_name = "DATA    BIN"
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  fat_pkg::read_phase_t phase,
    input  wire                  beat_fire,
    input  fat_pkg::byte_beat_t  beat,
    output logic                 file_found,
    output fat_pkg::cluster_t    file_cluster,
    output logic [31:0]          file_size
);
    import fat_pkg::*;

    logic [4:0] idx;             // byte position inside the entry
    logic [7:0] name_byte;
    logic       mismatch;
    logic       skip;            // free, deleted or subdirectory entry
    logic       scan;
    logic [7:0] tail [0:4];      // bytes 26 to 30

    assign idx  = beat.offset[4:0];
    assign scan = beat_fire && phase == phase_list_root;

    always_comb begin
        name_byte = 8'h20;
        for (int i = 0; i < 11; i++)
            if (idx == 5'(i))
                name_byte = target_name[8*(10-i) +: 8];  // first character is the MSB
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mismatch   <= 1'b0;
            skip       <= 1'b0;
            file_found <= 1'b0;
        end else if (scan) begin
            if (idx == 5'd0) begin
                mismatch <= beat.data != name_byte;
                skip     <= beat.data == 8'h00 || beat.data == 8'hE5;
            end else if (idx <= 5'd10) begin
                mismatch <= mismatch || beat.data != name_byte;
            end else if (idx == 5'd11 && beat.data[4]) begin
                skip <= 1'b1;                              // directory attribute
            end
            if (idx == 5'(dir_entry_bytes - 1) && !mismatch && !skip)
                file_found <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (scan && idx >= 5'd26 && idx <= 5'd30)
            tail[idx[2:0] - 3'd2] <= beat.data;
        if (scan && idx == 5'd31 && !mismatch && !skip && !file_found) begin
            file_cluster <= {tail[1], tail[0]};
            file_size    <= {beat.data, tail[4], tail[3], tail[2]};
        end
    end

endmodule

`default_nettype wire

// File: hw/fat_pkg.sv
// FAT16 format constants and the shared types of the reader
// sector request, sector byte beat, volume layout and read phase
`default_nettype none

package fat_pkg;

    localparam int unsigned sector_bytes    = 512;  // only supported sector size
    localparam int unsigned dir_entry_bytes = 32;   // one short-name directory entry

    typedef logic [31:0] sector_no_t;
    typedef logic [15:0] cluster_t;

    localparam cluster_t fat16_eoc_min = 16'hFFF0;  // end of chain and reserved values

    typedef struct packed {
        sector_no_t sector;                         // absolute sector to read
    } sector_req_t;

    typedef struct packed {
        logic [7:0] data;
        logic [8:0] offset;                         // byte position in the sector
        logic       last;                           // set at offset 511
    } byte_beat_t;

    // where the FAT16 regions start, taken from the boot record
    typedef struct packed {
        logic [7:0]  sec_per_clus;
        sector_no_t  fat_start;
        sector_no_t  root_start;
        logic [15:0] root_count;                    // root directory length in sectors
        sector_no_t  data_start;                    // sector of cluster 0
    } volume_layout_t;

    typedef enum logic [2:0] {
        phase_idle,
        phase_find_mbr,
        phase_find_dbr,
        phase_list_root,
        phase_read_fat,
        phase_read_file,
        phase_done
    } read_phase_t;

endpackage

`default_nettype wire

// File: hw/fat_reader_top.sv
// FAT16 file reader top level behind a sector block device
// connects boot record parser, directory matcher, sequencer and streamer
`timescale 1ns/1ps
`default_nettype none

module fat_reader_top #(
    parameter logic [8*11-1:0] target_name = "DATA    BIN"
) (
    input  wire                  clk,
    input  wire                  rst_n,
    output logic                 sector_req_valid,
    input  wire                  sector_req_ready,
    output fat_pkg::sector_req_t sector_req,
    input  wire                  sect_valid,
    output logic                 sect_ready,
    input  fat_pkg::byte_beat_t  sect_beat,
    output logic                 out_valid,
    input  wire                  out_ready,
    output logic [7:0]           out_byte,
    output logic                 file_found,
    output logic                 done
);
    import fat_pkg::*;

    read_phase_t    phase;
    volume_layout_t layout;
    sector_no_t     part_start;
    sector_no_t     base_sector;
    cluster_t       file_cluster;
    logic [31:0]    file_size;
    logic           is_boot;
    logic           is_dbr;
    logic           fs_ok;
    logic           beat_fire;

    assign beat_fire = sect_valid && sect_ready;

    boot_record_parser i_boot_record_parser (
        .clk, .rst_n, .phase, .beat_fire, .beat(sect_beat), .layout,
        .is_boot, .is_dbr, .part_start, .fs_ok, .base_sector
    );

    dir_entry_matcher #(.target_name(target_name)) i_dir_entry_matcher (
        .clk, .rst_n, .phase, .beat_fire, .beat(sect_beat),
        .file_found, .file_cluster, .file_size
    );

    fat_sequencer i_fat_sequencer (
        .clk, .rst_n, .sector_req_valid, .sector_req_ready, .sector_req,
        .beat_fire, .beat(sect_beat), .phase, .layout, .is_boot, .is_dbr, .fs_ok,
        .part_start, .file_found, .file_cluster, .base_sector, .done
    );

    file_byte_streamer i_file_byte_streamer (
        .clk, .rst_n, .phase, .file_size, .sect_valid, .sect_ready,
        .beat(sect_beat), .out_valid, .out_ready, .out_byte
    );

endmodule

`default_nettype wire

// File: hw/fat_sequencer.sv
// FAT16 read sequencer FSM
// walks boot record search, root listing and the cluster chain,
// issuing one sector request at a time and picking FAT16 entries
`timescale 1ns/1ps
`default_nettype none

module fat_sequencer (
    input  wire                     clk,
    input  wire                     rst_n,
    output logic                    sector_req_valid,
    input  wire                     sector_req_ready,
    output fat_pkg::sector_req_t    sector_req,
    input  wire                     beat_fire,
    input  fat_pkg::byte_beat_t     beat,
    output fat_pkg::read_phase_t    phase,
    input  fat_pkg::volume_layout_t layout,
    input  wire                     is_boot,
    input  wire                     is_dbr,
    input  wire                     fs_ok,
    input  fat_pkg::sector_no_t     part_start,
    input  wire                     file_found,
    input  fat_pkg::cluster_t       file_cluster,
    output fat_pkg::sector_no_t     base_sector,
    output logic                    done
);
    import fat_pkg::*;

    sector_no_t     sector_no;
    logic [15:0]    offs;            // sector index inside the root or the cluster
    logic [15:0]    next_offs;
    cluster_t       cur_cluster;
    cluster_t       fat_entry;       // next cluster read from the FAT
    volume_layout_t vol;             // layout kept once the boot record is accepted
    logic           req_arm;         // raise the request next cycle
    logic           waiting;         // request accepted, sector streaming in
    logic           decide;          // one cycle after the last beat

    function automatic sector_no_t data_sector(cluster_t c, logic [15:0] o);
        sector_no_t base;
        base = vol.data_start + {16'd0, c} * {24'd0, vol.sec_per_clus};
        return base + {16'd0, o};
    endfunction

    assign next_offs   = offs + 16'd1;
    assign base_sector = sector_no;
    assign sector_req  = '{sector: sector_no};
    assign done        = phase == phase_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase            <= phase_idle;
            sector_req_valid <= 1'b0;
            req_arm          <= 1'b0;
            waiting          <= 1'b0;
            decide           <= 1'b0;
            sector_no        <= '0;
            offs             <= '0;
            cur_cluster      <= '0;
        end else begin
            req_arm <= 1'b0;
            decide  <= 1'b0;
            if (req_arm)
                sector_req_valid <= 1'b1;
            if (sector_req_valid && sector_req_ready) begin
                sector_req_valid <= 1'b0;
                waiting          <= 1'b1;
            end
            if (waiting && beat_fire && beat.last) begin
                waiting <= 1'b0;
                decide  <= 1'b1;
            end

            if (phase == phase_idle) begin
                phase     <= phase_find_mbr;
                sector_no <= '0;
                req_arm   <= 1'b1;
            end else if (decide) begin
                req_arm <= 1'b1;                           // cleared again where we stop
                offs    <= '0;
                case (phase)
                    phase_find_mbr: begin
                        if (is_boot) begin
                            phase <= phase_find_dbr;
                            if (!is_dbr)
                                sector_no <= part_start;   // MBR, follow partition 1
                        end else begin
                            sector_no <= sector_no + 32'd1;
                        end
                    end
                    phase_find_dbr: begin
                        if (is_boot && is_dbr && fs_ok) begin
                            phase     <= phase_list_root;
                            sector_no <= layout.root_start;
                        end else begin
                            phase   <= phase_done;
                            req_arm <= 1'b0;
                        end
                    end
                    phase_list_root: begin
                        if (file_found && file_cluster >= 16'd2) begin
                            phase       <= phase_read_file;
                            cur_cluster <= file_cluster;
                            sector_no   <= data_sector(file_cluster, 16'd0);
                        end else if (!file_found && next_offs < vol.root_count) begin
                            offs      <= next_offs;
                            sector_no <= vol.root_start + {16'd0, next_offs};
                        end else begin
                            phase   <= phase_done;
                            req_arm <= 1'b0;
                        end
                    end
                    phase_read_file: begin
                        if (next_offs < {8'd0, vol.sec_per_clus}) begin
                            offs      <= next_offs;
                            sector_no <= data_sector(cur_cluster, next_offs);
                        end else begin
                            phase     <= phase_read_fat;   // 256 entries per FAT sector
                            sector_no <= vol.fat_start + {24'd0, cur_cluster[15:8]};
                        end
                    end
                    phase_read_fat: begin
                        if (fat_entry >= fat16_eoc_min || fat_entry < 16'd2) begin
                            phase   <= phase_done;
                            req_arm <= 1'b0;
                        end else begin
                            phase       <= phase_read_file;
                            cur_cluster <= fat_entry;
                            sector_no   <= data_sector(fat_entry, 16'd0);
                        end
                    end
                    default: req_arm <= 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decide && phase == phase_find_dbr)
            vol <= layout;
        if (phase == phase_read_fat && beat_fire && beat.offset[8:1] == cur_cluster[7:0]) begin
            if (beat.offset[0])
                fat_entry[15:8] <= beat.data;
            else
                fat_entry[7:0] <= beat.data;               // little endian entry
        end
    end

endmodule

`default_nettype wire

// File: hw/file_byte_streamer.sv
// file content streamer with valid/ready on both sides
// forwards data sector bytes until file size is reached
`timescale 1ns/1ps
`default_nettype none

module file_byte_streamer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  fat_pkg::read_phase_t phase,
    input  wire [31:0]           file_size,
    input  wire                  sect_valid,
    output logic                 sect_ready,
    input  fat_pkg::byte_beat_t  beat,
    output logic                 out_valid,
    input  wire                  out_ready,
    output logic [7:0]           out_byte
);
    import fat_pkg::*;

    logic [31:0] file_ptr;       // bytes already handed out
    logic        pass_byte;

    assign pass_byte = phase == phase_read_file && file_ptr < file_size;

    // sector stream stalls with the consumer only while content is passed
    assign out_valid  = sect_valid && pass_byte;
    assign out_byte   = beat.data;
    assign sect_ready = pass_byte ? out_ready : 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            file_ptr <= '0;
        else if (out_valid && out_ready)
            file_ptr <= file_ptr + 32'd1;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile the FAT16 reader testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_fat_reader -f build.f -o tb_fat_reader; then
    echo "compilation failed"
    exit 1
fi

if ! output=$(./obj_dir/tb_fat_reader); then
    printf '%s\n' "$output"
    echo "simulation exited with an error"
    exit 1
fi

printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: tests/tb_clock_gen.sv
// testbench clock and active low reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;      // released on a falling edge
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tests/tb_fat_reader.sv
// FAT16 reader testbench with a sparse sector disk model
// three DUT instances (file present, name missing, 1024 byte sectors)
// reference function, byte checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module sector_disk_model #(
    parameter bit boot_at_zero = 1'b0  // boot record at sector 0 with 1024 byte sectors
) (
    input  wire                  clk,
    input  wire                  sector_req_valid,
    output logic                 sector_req_ready,
    input  fat_pkg::sector_req_t sector_req,
    output logic                 sect_valid,
    input  wire                  sect_ready,
    output fat_pkg::byte_beat_t  sect_beat
);
    import fat_pkg::*;

    logic [7:0] image [int unsigned];  // keyed by sector * 512 + offset
    integer     seed;
    logic       fired;                 // beat taken at the last rising edge
    sector_no_t cur_sector;
    int         off;

    task automatic put_byte(int unsigned sec, int unsigned ofs, logic [7:0] val);
        image[sec * 512 + ofs] = val;
    endtask

    task automatic put_word(int unsigned sec, int unsigned ofs, logic [15:0] val);
        put_byte(sec, ofs, val[7:0]);      // little endian
        put_byte(sec, ofs + 1, val[15:8]);
    endtask

    task automatic put_name(int unsigned sec, int unsigned ofs, logic [8*11-1:0] name);
        for (int i = 0; i < 11; i++)
            put_byte(sec, ofs + i, name[8*(10-i) +: 8]);
    endtask

    function automatic logic [7:0] read_byte(sector_no_t sec, int unsigned ofs);
        int unsigned addr;
        addr = sec * 512 + ofs;
        if (image.exists(addr))
            return image[addr];
        return 8'(addr ^ (addr >> 8) ^ (addr >> 16) ^ (addr >> 24));  // unwritten bytes
    endfunction

    task automatic build_image();
        int unsigned chain [3];
        int unsigned k;
        chain = '{5, 9, 3};
        if (boot_at_zero) begin
            put_byte(0, 0, 8'hEB);
            put_word(0, 'h0B, 16'd1024);   // sector size the reader rejects
            put_word(0, 'h16, 16'd4);
            put_word(0, 'h1FE, 16'hAA55);
        end else begin
            put_byte(0, 0, 8'h33);         // MBR code, no jump opcode
            put_word(0, 'h1C6, 16'd8);     // partition 1 starts at sector 8
            put_word(0, 'h1C8, 16'd0);
            put_word(0, 'h1FE, 16'hAA55);
            // boot record: 2 sectors per cluster, 4 reserved, one FAT of 4 sectors
            put_byte(8, 0, 8'hEB);
            put_word(8, 'h0B, 16'd512);
            put_byte(8, 'h0D, 8'd2);
            put_word(8, 'h0E, 16'd4);
            put_byte(8, 'h10, 8'd1);
            put_word(8, 'h11, 16'd32);     // 32 root entries, 2 sectors
            put_word(8, 'h16, 16'd4);
            put_word(8, 'h1FE, 16'hAA55);
            // FAT at sector 12
            put_word(12, 0, 16'hFFF8);
            put_word(12, 2, 16'hFFFF);
            for (int i = 0; i < 3; i++)
                put_word(12, 2 * chain[i], i < 2 ? 16'(chain[i + 1]) : 16'hFFFF);
            // root at 16, subdirectory and deleted entry carry the same name
            put_name(16, 0, "DATA    BIN");
            put_byte(16, 11, 8'h10);
            put_name(16, 32, "DATA    BIN");
            put_byte(16, 32, 8'hE5);
            put_byte(16, 43, 8'h20);
            put_name(17, 96, "DATA    BIN"); // the file, in the second root sector
            put_byte(17, 107, 8'h20);
            put_word(17, 122, 16'd5);
            put_word(17, 124, 16'd1500);
            put_word(17, 126, 16'd0);
            // data area, cluster c starts at sector 14 + 2 * c
            for (int i = 0; i < 1500; i++) begin
                k = i / 1024;
                put_byte(14 + 2 * chain[k] + (i % 1024) / 512, i % 512, 8'(i * 7 + k));
            end
        end
    endtask

    always @(posedge clk)
        fired <= sect_valid && sect_ready;

    initial begin
        seed             = 32'hca3b09be;
        sector_req_ready = 1'b0;
        sect_valid       = 1'b0;
        sect_beat        = '0;
        build_image();
        forever begin
            @(negedge clk);
            if (sector_req_valid) begin
                cur_sector       = sector_req.sector;
                sector_req_ready = 1'b1;
                @(negedge clk);
                sector_req_ready = 1'b0;
                off = 0;
                while (off < 512) begin
                    sect_valid = ($random(seed) & 3) != 0;  // idle a quarter of the time
                    sect_beat  = '{data: read_byte(cur_sector, off), offset: 9'(off),
                                   last: off == 511};
                    @(negedge clk);
                    while (sect_valid && !fired)
                        @(negedge clk);                     // held until taken
                    if (sect_valid)
                        off++;
                end
                sect_valid = 1'b0;
            end
        end
    end

endmodule

module tb_fat_reader;
    import fat_pkg::*;

    localparam int clk_period_ns = 40;
    localparam int file_len      = 1500;
    localparam int sector_reads  = 13;   // MBR, VBR, 2 root, 6 data, 3 FAT
    localparam int timeout_ns    = sector_reads * 512 * 3 * clk_period_ns;  // 3 cycles per beat

    logic        clk;
    logic        rst_n;
    logic        req_valid [3];
    logic        req_ready [3];
    sector_req_t req [3];
    logic        sect_valid [3];
    logic        sect_ready [3];
    byte_beat_t  sect_beat [3];
    logic        out_valid [3];
    logic        out_ready [3];
    logic [7:0]  out_byte [3];
    logic        file_found [3];
    logic        done [3];
    int          rx_count [3];
    int          req_count [3];
    int          data_errors;
    int          status_errors;
    integer      seed;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(2)) i_tb_clock_gen (
        .clk, .rst_n
    );

    fat_reader_top #(.target_name("DATA    BIN")) i_fat_reader_top (
        .clk, .rst_n, .sector_req_valid(req_valid[0]), .sector_req_ready(req_ready[0]),
        .sector_req(req[0]), .sect_valid(sect_valid[0]), .sect_ready(sect_ready[0]),
        .sect_beat(sect_beat[0]), .out_valid(out_valid[0]), .out_ready(out_ready[0]),
        .out_byte(out_byte[0]), .file_found(file_found[0]), .done(done[0])
    );

    fat_reader_top #(.target_name("MISSING TXT")) i_fat_reader_top_miss (
        .clk, .rst_n, .sector_req_valid(req_valid[1]), .sector_req_ready(req_ready[1]),
        .sector_req(req[1]), .sect_valid(sect_valid[1]), .sect_ready(sect_ready[1]),
        .sect_beat(sect_beat[1]), .out_valid(out_valid[1]), .out_ready(out_ready[1]),
        .out_byte(out_byte[1]), .file_found(file_found[1]), .done(done[1])
    );

    fat_reader_top #(.target_name("DATA    BIN")) i_fat_reader_top_bad (
        .clk, .rst_n, .sector_req_valid(req_valid[2]), .sector_req_ready(req_ready[2]),
        .sector_req(req[2]), .sect_valid(sect_valid[2]), .sect_ready(sect_ready[2]),
        .sect_beat(sect_beat[2]), .out_valid(out_valid[2]), .out_ready(out_ready[2]),
        .out_byte(out_byte[2]), .file_found(file_found[2]), .done(done[2])
    );

    sector_disk_model #(.boot_at_zero(1'b0)) i_disk_main (
        .clk, .sector_req_valid(req_valid[0]), .sector_req_ready(req_ready[0]),
        .sector_req(req[0]), .sect_valid(sect_valid[0]), .sect_ready(sect_ready[0]),
        .sect_beat(sect_beat[0])
    );

    sector_disk_model #(.boot_at_zero(1'b0)) i_disk_miss (
        .clk, .sector_req_valid(req_valid[1]), .sector_req_ready(req_ready[1]),
        .sector_req(req[1]), .sect_valid(sect_valid[1]), .sect_ready(sect_ready[1]),
        .sect_beat(sect_beat[1])
    );

    sector_disk_model #(.boot_at_zero(1'b1)) i_disk_bad (
        .clk, .sector_req_valid(req_valid[2]), .sector_req_ready(req_ready[2]),
        .sector_req(req[2]), .sect_valid(sect_valid[2]), .sect_ready(sect_ready[2]),
        .sect_beat(sect_beat[2])
    );

    // file byte i is the low byte of 7 * i plus its cluster's place in the chain
    function automatic logic [7:0] ref_byte(int i);
        return 8'(i * 7 + i / 1024);     // 1024 bytes per cluster
    endfunction

    // MBR, boot record, root sectors, then each cluster's two sectors and its FAT sector
    function automatic int expected_sector(int n, int idx);
        int main_seq [13];
        main_seq = '{0, 8, 16, 17, 24, 25, 12, 32, 33, 12, 20, 21, 12};
        if (n == 2)
            return 0;                    // boot record at sector 0, read twice
        if (idx < 13)
            return main_seq[idx];
        return -1;
    endfunction

    task automatic check_value(string name, int actual, int expected);
        assert (actual == expected)
            else begin
                status_errors++;
                $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            end
    endtask

    always @(negedge clk)
        out_ready[0] = ($random(seed) & 3) != 0;   // consumer stalls now and then

    always @(posedge clk) begin
        logic [7:0] expected;
        if (out_valid[0] && out_ready[0]) begin
            expected = ref_byte(rx_count[0]);
            assert (rx_count[0] < file_len)
                else begin
                    data_errors++;
                    $display("more bytes came out than the file holds at %0t", $time);
                end
            assert (out_byte[0] == expected)
                else begin
                    data_errors++;
                    $display("FAILED at %0t: out_byte (index %0d) = %h, expected %h",
                             $time, rx_count[0], out_byte[0], expected);
                end
            rx_count[0]++;
        end
        for (int n = 1; n < 3; n++)
            if (out_valid[n] && out_ready[n])
                rx_count[n]++;
        for (int n = 0; n < 3; n++)
            if (req_valid[n] && req_ready[n]) begin
                check_value("sector_req.sector", int'(req[n].sector),
                            expected_sector(n, req_count[n]));
                req_count[n]++;
            end
    end

    initial begin
        seed          = 32'hca3b09be;
        data_errors   = 0;
        status_errors = 0;
        for (int n = 0; n < 3; n++) begin
            out_ready[n] = 1'b1;
            rx_count[n]  = 0;
            req_count[n] = 0;
        end
        @(negedge clk);                  // still in reset
        for (int n = 0; n < 3; n++) begin
            check_value("sector_req_valid in reset", int'(req_valid[n]), 0);
            check_value("out_valid in reset", int'(out_valid[n]), 0);
            check_value("file_found in reset", int'(file_found[n]), 0);
            check_value("done in reset", int'(done[n]), 0);
        end
        wait (rst_n);
        wait (done[0] && done[1] && done[2]);
        repeat (4) @(negedge clk);
        check_value("file_found", int'(file_found[0]), 1);
        check_value("bytes out", rx_count[0], file_len);
        check_value("sector requests", req_count[0], sector_reads);
        check_value("file_found, missing name", int'(file_found[1]), 0);
        check_value("bytes out, missing name", rx_count[1], 0);
        check_value("sector requests, missing name", req_count[1], 4);
        check_value("file_found, 1024 byte sectors", int'(file_found[2]), 0);
        check_value("bytes out, 1024 byte sectors", rx_count[2], 0);
        check_value("sector requests, 1024 byte sectors", req_count[2], 2);
        $display("errors: %0d data, %0d status", data_errors, status_errors);
        if (data_errors + status_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: not every instance reached done within %0d ns", timeout_ns);
        $display("errors: %0d data, %0d status", data_errors, status_errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
